//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_fme7
FILELIST = project.f

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- fme7_addr_map.sv
// FME-7 address translation
`timescale 1ns/1ps

module fme7_addr_map (
	input  fme7_pkg::bank_state_t banks,
	input  fme7_pkg::cpu_bus_t    cpu,
	input  fme7_pkg::chr_addr_t   chr_ain,
	output fme7_pkg::mem_addr_t   prg_aout,
	output logic                  prg_allow,
	output fme7_pkg::mem_addr_t   chr_aout,
	output logic                  vram_a10,
	output logic                  vram_ce
);
	import fme7_pkg::*;

	prg_bank_t  prg_sel;    // Bank for the current CPU window
	logic       ram_cs;     // 0x6000 window routed to PRG RAM
	logic [3:0] prg_prefix;
	chr_bank_t  chr_sel;

	// 8 kB windows by CPU A15-A13
	always_comb begin
		case (cpu.addr[15:13])
			3'b011:  prg_sel = banks.prg_bank[0]; // 0x6000
			3'b100:  prg_sel = banks.prg_bank[1]; // 0x8000
			3'b101:  prg_sel = banks.prg_bank[2]; // 0xA000
			3'b110:  prg_sel = banks.prg_bank[3]; // 0xC000
			default: prg_sel = PRG_FIXED_BANK;    // 0xE000, below 0x6000 is refused anyway
		endcase
	end

	assign ram_cs     = (cpu.addr[15:13] == PRG_RAM_BASE[15:13]) && banks.ram_select;
	assign prg_prefix = ram_cs ? PRG_RAM_PREFIX : 4'b0000;
	assign prg_aout   = {prg_prefix, prg_sel, cpu.addr[12:0]};

	// RAM obeys the enable bit for both directions, ROM is read only
	always_comb begin
		if (cpu.addr < PRG_RAM_BASE) begin
			prg_allow = 1'b0;
		end else if (ram_cs) begin
			prg_allow = banks.ram_enable;
		end else begin
			prg_allow = !cpu.write;
		end
	end

	assign chr_sel  = banks.chr_bank[chr_ain[12:10]]; // 1 kB windows
	assign chr_aout = {CHR_ROM_PREFIX, chr_sel, chr_ain[9:0]};

	always_comb begin
		case (banks.mirror)
			MIRROR_VERTICAL:   vram_a10 = chr_ain[10];
			MIRROR_HORIZONTAL: vram_a10 = chr_ain[11];
			default:           vram_a10 = banks.mirror[0]; // One-screen lower or upper
		endcase
	end

	assign vram_ce = chr_ain[13]; // Nametable space goes to internal VRAM

endmodule

//--- fme7_bank_regs.sv
// FME-7 bank register file
`timescale 1ns/1ps

module fme7_bank_regs (
	input  logic                  clk,
	input  logic                  arst_n,
	input  fme7_pkg::reg_wr_t     reg_wr,
	output fme7_pkg::bank_state_t banks
);
	import fme7_pkg::*;

	logic chr_sel;    // Index 0-7
	logic prg_sel;    // Index 8-11
	logic mirror_sel; // Index 12
	logic ram_sel;    // Index 8 carries the RAM bits too

	always_comb begin
		chr_sel    = reg_wr.valid && (reg_wr.index < REG_PRG_FIRST);
		prg_sel    = reg_wr.valid && (reg_wr.index >= REG_PRG_FIRST) &&
			(reg_wr.index < REG_MIRROR);
		mirror_sel = reg_wr.valid && (reg_wr.index == REG_MIRROR);
		ram_sel    = reg_wr.valid && (reg_wr.index == REG_PRG_FIRST);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			banks <= '0;
		end else begin
			if (chr_sel) begin
				banks.chr_bank[reg_wr.index[2:0]] <= reg_wr.data; // Full byte
			end
			if (prg_sel) begin
				banks.prg_bank[reg_wr.index[1:0]] <= reg_wr.data[4:0];
			end
			if (mirror_sel) begin
				banks.mirror <= reg_wr.data[1:0];
			end
			if (ram_sel) begin
				banks.ram_enable <= reg_wr.data[7];
				banks.ram_select <= reg_wr.data[6];
			end
		end
	end

endmodule

//--- fme7_checker.sv
// FME-7 response checker
`timescale 1ns/1ps

module fme7_checker (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                ce,
	input  fme7_pkg::cpu_bus_t  cpu,
	input  fme7_pkg::chr_addr_t chr_ain,
	input  fme7_pkg::mem_addr_t prg_aout,
	input  logic                prg_allow,
	input  fme7_pkg::mem_addr_t chr_aout,
	input  logic                vram_a10,
	input  logic                vram_ce,
	input  logic                irq,
	input  logic                req_valid,
	input  logic [2:0]          req_op,
	input  logic [15:0]         req_value,
	input  logic [15:0]         req_exp,
	output int                  pass_count,
	output int                  fail_count
);
	import fme7_pkg::*;

	reg_index_t cmd;        // Model of the command latch
	chr_bank_t  chr_m [8];
	prg_bank_t  prg_m [4];
	mirror_t    mir;
	logic       ren;
	logic       rsel;
	irq_count_t loaded;     // Counter value as written

	logic [2:0] win;
	prg_bank_t  bank;
	logic       is_ram;
	mem_addr_t  exp_a;
	logic       exp_allow;
	logic       exp_a10;

	initial begin
		pass_count = 0;
		fail_count = 0;
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd <= '0;
			mir <= '0;
			ren <= 1'b0;
			rsel <= 1'b0;
			loaded <= '0;
			for (int i = 0; i < 8; i++) chr_m[i] <= '0;
			for (int i = 0; i < 4; i++) prg_m[i] <= '0;
		end else begin
			if (req_valid) begin
				case (req_op)
					3'd1: begin
						win = cpu.addr[15:13];
						if (win == 3'd3) bank = prg_m[0];
						else if (win == 3'd4) bank = prg_m[1];
						else if (win == 3'd5) bank = prg_m[2];
						else if (win == 3'd6) bank = prg_m[3];
						else bank = 5'h1F; // Last bank of the ROM
						is_ram = (win == 3'd3) && rsel;
						exp_a = {is_ram ? 4'hF : 4'h0, bank, cpu.addr[12:0]};
						if (cpu.addr < 16'h6000) exp_allow = 1'b0;
						else if (is_ram) exp_allow = ren;
						else exp_allow = !cpu.write;
						if (prg_aout !== exp_a || prg_allow !== exp_allow) begin
							$display("mismatch at %0t: prg %h wr %b got %h/%b expected %h/%b",
								$time, cpu.addr, cpu.write, prg_aout, prg_allow, exp_a, exp_allow);
							fail_count++;
						end else begin
							$display("prg %h wr %b -> %h allow %b ok",
								cpu.addr, cpu.write, prg_aout, prg_allow);
							pass_count++;
						end
					end
					3'd2: begin
						exp_a = {4'h8, chr_m[chr_ain[12:10]], chr_ain[9:0]};
						case (mir)
							2'd0:    exp_a10 = chr_ain[10];
							2'd1:    exp_a10 = chr_ain[11];
							2'd2:    exp_a10 = 1'b0;
							default: exp_a10 = 1'b1;
						endcase
						if (chr_aout !== exp_a || vram_a10 !== exp_a10 ||
								vram_ce !== chr_ain[13]) begin
							$display("mismatch at %0t: chr %h got %h/%b/%b expected %h/%b/%b",
								$time, chr_ain, chr_aout, vram_a10, vram_ce,
								exp_a, exp_a10, chr_ain[13]);
							fail_count++;
						end else begin
							$display("chr %h -> %h a10 %b ce %b ok",
								chr_ain, chr_aout, vram_a10, vram_ce);
							pass_count++;
						end
					end
					3'd3: begin
						// Load N, underflow on the step after reaching zero
						if (req_value !== loaded + 16'd1 || irq !== req_exp[0]) begin
							$display("mismatch at %0t: irq rose after %0d ce cycles, expected %0d",
								$time, req_value, loaded + 16'd1);
							fail_count++;
						end else begin
							$display("irq rose after %0d ce cycles ok", req_value);
							pass_count++;
						end
					end
					3'd4: begin
						if (req_value !== req_exp) begin
							$display("mismatch at %0t: irq seen high %0d times, expected %0d",
								$time, req_value, req_exp);
							fail_count++;
						end else begin
							$display("irq stayed low ok");
							pass_count++;
						end
					end
					default: begin
						if (req_value == 16'd0) $display("timed out waiting for a CPU write cycle");
						else if (req_value == 16'd1) $display("irq never rose before the time limit");
						else $display("ran out of time waiting for CPU cycles");
						fail_count++;
					end
				endcase
			end
			// Register model follows the bus writes
			if (ce && cpu.write) begin
				if (cpu.addr >= 16'h8000 && cpu.addr < 16'hA000) begin
					cmd <= cpu.data[3:0];
				end else if (cpu.addr >= 16'hA000 && cpu.addr < 16'hC000) begin
					if (cmd < 4'd8) chr_m[cmd[2:0]] <= cpu.data;
					else if (cmd < 4'd12) prg_m[cmd[1:0]] <= cpu.data[4:0];
					if (cmd == 4'd8) begin
						ren <= cpu.data[7];
						rsel <= cpu.data[6];
					end
					if (cmd == 4'd12) mir <= cpu.data[1:0];
					if (cmd == 4'd14) loaded[7:0] <= cpu.data;
					if (cmd == 4'd15) loaded[15:8] <= cpu.data;
				end
			end
		end
	end

endmodule

//--- fme7_irq_timer.sv
// FME-7 IRQ down-counter
`timescale 1ns/1ps

module fme7_irq_timer (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              ce,
	input  fme7_pkg::reg_wr_t reg_wr,
	output logic              irq
);
	import fme7_pkg::*;

	irq_count_t  counter;
	logic        countdown; // Counter runs
	logic        trigger;   // Underflow raises irq
	logic [16:0] next_count; // Borrow in the top bit

	assign next_count = {1'b0, counter} - {16'b0, countdown};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			counter   <= '0;
			countdown <= 1'b0;
			trigger   <= 1'b0;
			irq       <= 1'b0;
		end else if (ce) begin
			counter <= next_count[15:0];

			// A byte load overrides only its half of the decremented value
			if (reg_wr.valid) begin
				case (reg_wr.index)
					REG_IRQ_CTRL: begin
						countdown <= reg_wr.data[7];
						trigger   <= reg_wr.data[0];
					end
					REG_IRQ_LO: counter[7:0]  <= reg_wr.data;
					REG_IRQ_HI: counter[15:8] <= reg_wr.data;
					default: ;                // Bank registers
				endcase
			end

			if (!trigger) begin
				irq <= 1'b0;
			end else if (next_count[16]) begin
				irq <= 1'b1; // Wrapped past zero
			end
		end
	end

	// The line can only go up on a CPU cycle that had the trigger armed
	a_irq_needs_trigger: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(irq) |-> $past(ce && trigger)
	) else $error("irq rose while the trigger was off");

endmodule

//--- fme7_pkg.sv
// FME-7 mapper definitions
package fme7_pkg;

	typedef logic [15:0] cpu_addr_t;  // CPU bus address
	typedef logic [7:0]  cpu_data_t;  // CPU data byte
	typedef logic [13:0] chr_addr_t;  // PPU address
	typedef logic [21:0] mem_addr_t;  // Translated memory address
	typedef logic [7:0]  chr_bank_t;  // 1 kB CHR bank number
	typedef logic [4:0]  prg_bank_t;  // 8 kB PRG bank number
	typedef logic [3:0]  reg_index_t; // Command register index
	typedef logic [15:0] irq_count_t; // IRQ down-counter

	// 0 vertical, 1 horizontal, 2 one-screen lower, 3 one-screen upper
	typedef logic [1:0] mirror_t;

	localparam int NUM_CHR_BANKS = 8;
	localparam int NUM_PRG_BANKS = 4;

	// Command indices
	localparam reg_index_t REG_PRG_FIRST = 4'd8;  // First PRG bank register, also RAM control
	localparam reg_index_t REG_MIRROR    = 4'd12;
	localparam reg_index_t REG_IRQ_CTRL  = 4'd13; // Countdown and trigger enable
	localparam reg_index_t REG_IRQ_LO    = 4'd14;
	localparam reg_index_t REG_IRQ_HI    = 4'd15;

	localparam mirror_t MIRROR_VERTICAL   = 2'd0;
	localparam mirror_t MIRROR_HORIZONTAL = 2'd1;

	localparam prg_bank_t PRG_FIXED_BANK = 5'b11111; // Always at 0xE000
	localparam logic [3:0] PRG_RAM_PREFIX = 4'b1111;
	localparam logic [3:0] CHR_ROM_PREFIX = 4'b1000;
	localparam cpu_addr_t PRG_RAM_BASE = 16'h6000;

	// CPU bus as seen by the mapper
	typedef struct packed {
		cpu_addr_t addr;
		logic      write;
		cpu_data_t data;
	} cpu_bus_t;

	// Register write request from the decoder
	typedef struct packed {
		logic       valid;
		reg_index_t index;
		cpu_data_t  data;
	} reg_wr_t;

	// Everything the address mapper needs from the register file
	typedef struct packed {
		chr_bank_t [NUM_CHR_BANKS-1:0] chr_bank;
		prg_bank_t [NUM_PRG_BANKS-1:0] prg_bank;
		mirror_t                       mirror;
		logic                          ram_enable; // PRG RAM access allowed
		logic                          ram_select; // 0x6000 window goes to RAM
	} bank_state_t;

endpackage

//--- fme7_reg_decode.sv
// FME-7 CPU write decoder
`timescale 1ns/1ps

module fme7_reg_decode (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               ce,
	input  fme7_pkg::cpu_bus_t cpu,
	output fme7_pkg::reg_wr_t  reg_wr
);
	import fme7_pkg::*;

	reg_index_t command;    // Index selected by the last 0x8000 write
	logic       cmd_write;  // 0x8000-0x9FFF
	logic       param_write; // 0xA000-0xBFFF

	// Anything from 0xC000 upward falls through both decodes
	assign cmd_write   = ce && cpu.write && (cpu.addr[15:13] == 3'b100);
	assign param_write = ce && cpu.write && (cpu.addr[15:13] == 3'b101);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			command <= '0;
		end else if (cmd_write) begin
			command <= cpu.data[3:0]; // Low nibble only
		end
	end

	always_comb begin
		reg_wr.valid = param_write;
		reg_wr.index = command;
		reg_wr.data  = cpu.data;
	end

	// Downstream registers rely on requests lining up with a CPU cycle
	a_valid_needs_ce: assert property (
		@(posedge clk) disable iff (!arst_n)
		reg_wr.valid |-> ce && cpu.write
	) else $error("register write request outside a CPU write cycle");

endmodule

//--- fme7_top.sv
// FME-7 mapper top level
`timescale 1ns/1ps

module fme7_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                ce,
	input  fme7_pkg::cpu_bus_t  cpu,
	input  fme7_pkg::chr_addr_t chr_ain,
	output fme7_pkg::mem_addr_t prg_aout,
	output logic                prg_allow,
	output fme7_pkg::mem_addr_t chr_aout,
	output logic                vram_a10,
	output logic                vram_ce,
	output logic                irq
);
	import fme7_pkg::*;

	reg_wr_t     reg_wr; // Shared by register file and timer
	bank_state_t banks;

	fme7_reg_decode fme7_reg_decode_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.ce     (ce),
		.cpu    (cpu),
		.reg_wr (reg_wr)
	);

	fme7_bank_regs fme7_bank_regs_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.reg_wr (reg_wr),
		.banks  (banks)
	);

	fme7_irq_timer fme7_irq_timer_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.ce     (ce),
		.reg_wr (reg_wr),
		.irq    (irq)
	);

	fme7_addr_map fme7_addr_map_inst (
		.banks     (banks),
		.cpu       (cpu),
		.chr_ain   (chr_ain),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce)
	);

endmodule

//--- project.f
fme7_pkg.sv
fme7_reg_decode.sv
fme7_bank_regs.sv
fme7_irq_timer.sv
fme7_addr_map.sv
fme7_top.sv
fme7_checker.sv
tb_fme7.sv

//--- tb_fme7.sv
// FME-7 mapper testbench
`timescale 1ns/1ps

module tb_fme7;
	import fme7_pkg::*;

	localparam logic [2:0] ROW_WRITE = 3'd0;
	localparam logic [2:0] ROW_PRG   = 3'd1;
	localparam logic [2:0] ROW_CHR   = 3'd2;
	localparam logic [2:0] ROW_IRQ   = 3'd3; // data is the wait mode

	localparam logic [2:0] REQ_PRG      = 3'd1;
	localparam logic [2:0] REQ_CHR      = 3'd2;
	localparam logic [2:0] REQ_IRQ_RISE = 3'd3;
	localparam logic [2:0] REQ_IRQ_LOW  = 3'd4;
	localparam logic [2:0] REQ_TIMEOUT  = 3'd5;

	localparam int WAIT_LIMIT  = 16;  // Clocks to find a ce cycle
	localparam int IRQ_LIMIT   = 400; // Clocks for any IRQ wait
	localparam int QUIET_EDGES = 40;  // ce edges with irq held low

	typedef struct packed {
		logic [2:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [15:0] exp_val;
	} row_t;

	logic      clk = 1'b0;
	logic      arst_n;
	logic      ce;
	logic [1:0] ce_div;
	cpu_bus_t  cpu;
	chr_addr_t chr_ain;
	mem_addr_t prg_aout;
	logic      prg_allow;
	mem_addr_t chr_aout;
	logic      vram_a10;
	logic      vram_ce;
	logic      irq;

	logic        req_valid;
	logic [2:0]  req_op;
	logic [15:0] req_value;
	logic [15:0] req_exp;
	int          pass_count;
	int          fail_count;

	row_t table_q[$];
	int   seed = 62;
	int   r;

	fme7_top fme7_top_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.ce        (ce),
		.cpu       (cpu),
		.chr_ain   (chr_ain),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce),
		.irq       (irq)
	);

	fme7_checker fme7_checker_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.ce         (ce),
		.cpu        (cpu),
		.chr_ain    (chr_ain),
		.prg_aout   (prg_aout),
		.prg_allow  (prg_allow),
		.chr_aout   (chr_aout),
		.vram_a10   (vram_a10),
		.vram_ce    (vram_ce),
		.irq        (irq),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_value  (req_value),
		.req_exp    (req_exp),
		.pass_count (pass_count),
		.fail_count (fail_count)
	);

	always #10 clk = ~clk;

	// One CPU cycle in four
	always @(negedge clk) begin
		ce_div = ce_div + 2'd1;
		ce = (ce_div == 2'd0);
	end

	task automatic add_row(input logic [2:0] op, input logic [15:0] addr,
			input logic [7:0] data, input logic [15:0] exp_val);
		row_t row;
		row.op = op;
		row.addr = addr;
		row.data = data;
		row.exp_val = exp_val;
		table_q.push_back(row);
	endtask

	task automatic add_cmd(input logic [3:0] idx, input logic [7:0] data);
		add_row(ROW_WRITE, 16'h8000, {4'h0, idx}, 16'h0); // Command latch
		add_row(ROW_WRITE, 16'hA000, data, 16'h0);        // Parameter
	endtask

	// Called on a falling edge, held for one clock
	task automatic send_req(input logic [2:0] op, input logic [15:0] value,
			input logic [15:0] exp_val);
		req_op = op;
		req_value = value;
		req_exp = exp_val;
		req_valid = 1'b1;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		int   n;
		logic taken;
		n = 0;
		taken = 1'b0;
		@(negedge clk);
		cpu.addr = addr;
		cpu.data = data;
		cpu.write = 1'b1;
		while (!taken && n < WAIT_LIMIT) begin
			@(posedge clk);
			taken = ce;
			n++;
		end
		@(negedge clk);
		cpu.write = 1'b0;
		if (!taken) begin
			send_req(REQ_TIMEOUT, 16'd0, 16'd0);
		end
	endtask

	task automatic probe_prg(input logic [15:0] addr, input logic wr);
		@(negedge clk);
		cpu.addr = addr;
		cpu.write = wr;
		cpu.data = 8'h00;
		send_req(REQ_PRG, 16'd0, 16'd0);
		cpu.write = 1'b0;
	endtask

	task automatic probe_chr(input logic [15:0] addr);
		@(negedge clk);
		chr_ain = addr[13:0];
		send_req(REQ_CHR, 16'd0, 16'd0);
	endtask

	// Mode 0 counts ce edges up to the rise, 1 watches a quiet stretch, 2 one edge
	task automatic irq_wait(input logic [7:0] mode, input logic [15:0] exp_val);
		int   edges;
		int   highs;
		int   loops;
		int   target;
		logic seen;
		edges = 0;
		highs = 0;
		loops = 0;
		seen = 1'b0;
		target = (mode == 8'd1) ? QUIET_EDGES : 1;
		if (mode == 8'd0) begin
			while (!seen && loops < IRQ_LIMIT) begin
				@(posedge clk);
				if (ce) edges++;
				@(negedge clk);
				seen = irq;
				loops++;
			end
			if (seen) send_req(REQ_IRQ_RISE, 16'(edges), exp_val);
			else send_req(REQ_TIMEOUT, 16'd1, 16'd0);
		end else begin
			while (edges < target && loops < IRQ_LIMIT) begin
				@(posedge clk);
				if (ce) edges++;
				@(negedge clk);
				if (irq) highs++;
				loops++;
			end
			if (edges < target) send_req(REQ_TIMEOUT, 16'd2, 16'd0);
			else if (mode == 8'd2) send_req(REQ_IRQ_LOW, {15'd0, irq}, exp_val);
			else send_req(REQ_IRQ_LOW, 16'(highs), exp_val);
		end
	endtask

	task automatic build_table();
		// Reset state
		add_row(ROW_IRQ, 16'h0000, 8'd2, 16'd0);
		add_row(ROW_PRG, 16'hE000, 8'd0, 16'd0);
		add_row(ROW_PRG, 16'h8000, 8'd0, 16'd0);
		add_row(ROW_PRG, 16'h8000, 8'd1, 16'd0);
		// PRG banking with random banks
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			add_cmd(4'(8 + i), r[7:0]);
		end
		add_row(ROW_PRG, 16'h6123, 8'd0, 16'd0);
		add_row(ROW_PRG, 16'h8ABC, 8'd0, 16'd0);
		add_row(ROW_PRG, 16'hB5A5, 8'd0, 16'd0);
		add_row(ROW_PRG, 16'hDFFF, 8'd0, 16'd0);
		add_row(ROW_PRG, 16'hE001, 8'd0, 16'd0);
		// PRG RAM selected, first disabled then enabled
		r = $random(seed);
		add_cmd(4'd8, {3'b010, r[4:0]});
		add_row(ROW_PRG, 16'h6010, 8'd0, 16'd0);
		add_row(ROW_PRG, 16'h7FFF, 8'd1, 16'd0);
		add_cmd(4'd8, {3'b110, r[12:8]});
		add_row(ROW_PRG, 16'h6010, 8'd1, 16'd0);
		add_row(ROW_PRG, 16'h7A55, 8'd0, 16'd0);
		// CHR banking
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			add_cmd(4'(i), r[7:0]);
		end
		for (int i = 0; i < 8; i++) begin
			add_row(ROW_CHR, 16'(i * 1024 + i * 17 + 3), 8'd0, 16'd0);
		end
		add_row(ROW_CHR, 16'h2ABC, 8'd0, 16'd0);
		add_row(ROW_CHR, 16'h3C01, 8'd0, 16'd0);
		// Mirroring, probes differ in bits 10 and 11
		for (int m = 0; m < 4; m++) begin
			add_cmd(4'd12, 8'(m));
			add_row(ROW_CHR, 16'h2400, 8'd0, 16'd0);
			add_row(ROW_CHR, 16'h2800, 8'd0, 16'd0);
			add_row(ROW_CHR, 16'h2C00, 8'd0, 16'd0);
		end
		// IRQ: load 5 with the counter stopped, then start it
		add_cmd(4'd13, 8'h00);
		add_cmd(4'd15, 8'h00);
		add_cmd(4'd14, 8'h05);
		add_cmd(4'd13, 8'h81);
		add_row(ROW_IRQ, 16'h0000, 8'd0, 16'd1);
		add_cmd(4'd13, 8'h80); // Trigger off
		add_row(ROW_IRQ, 16'h0000, 8'd2, 16'd0);
		add_cmd(4'd15, 8'h00);
		add_cmd(4'd14, 8'h09);
		add_cmd(4'd13, 8'h01); // Countdown off, trigger on
		add_row(ROW_IRQ, 16'h0000, 8'd1, 16'd0);
	endtask

	initial begin
		arst_n = 1'b0;
		ce = 1'b0;
		ce_div = 2'd0;
		cpu = '0;
		chr_ain = '0;
		req_valid = 1'b0;
		req_op = 3'd0;
		req_value = 16'd0;
		req_exp = 16'd0;
		build_table();
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		foreach (table_q[i]) begin
			case (table_q[i].op)
				ROW_WRITE: bus_write(table_q[i].addr, table_q[i].data);
				ROW_PRG:   probe_prg(table_q[i].addr, table_q[i].data[0]);
				ROW_CHR:   probe_chr(table_q[i].addr);
				default:   irq_wait(table_q[i].data, table_q[i].exp_val);
			endcase
		end
		repeat (2) @(negedge clk);
		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && pass_count > 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
